// ==== logic/sigma_cpu_consts.svh ====
// sigma cpu constants
`ifndef SIGMA_CPU_CONSTS_SVH
`define SIGMA_CPU_CONSTS_SVH

// data word width
`define CPU_WORD_BITS 32

// word address width, 128K words
`define CPU_ADDR_BITS 17

// bytes per word, lane 0 is the most significant byte
`define CPU_BYTE_LANES 4

// private registers, also the aliased low address range
`define CPU_PRIVATE_REGS 16

// first word fetched after reset
`define CPU_RESET_WORD 17'h00025

// immediate field width before sign extension
`define CPU_IMM_BITS 20

`endif

// ==== logic/sigma_cpu_pkg.sv ====
// sigma cpu types
`include "sigma_cpu_consts.svh"

package sigma_cpu_pkg;

    // instruction codes kept from the full opcode map
    typedef enum logic [6:0] {
        OP_LI  = 7'h22,
        OP_BAL = 7'h6A,
        OP_LB  = 7'h72,
        OP_STB = 7'h75
    } opcode_e;

    typedef enum logic [2:0] {
        FETCH,
        PREP1,
        PREP2,
        EXEC1,
        EXEC2,
        EXEC3
    } phase_e;

    // sum bus operation
    typedef enum logic {
        PASS_D,
        ADD
    } sum_op_e;

    typedef struct packed {
        opcode_e                   opcode;
        logic [3:0]                reg_num;
        logic [2:0]                index_num;
        logic                      indirect;
        logic                      fam_b;
        logic                      fam_h;
        logic                      fam_w;
        logic [`CPU_WORD_BITS-1:0] immediate;
    } instr_t;

    typedef struct packed {
        logic    load_operand;
        logic    load_accumulator;
        logic    write_register;
        logic    test_accumulator;
        logic    store_request;
        sum_op_e sum_op;
    } dp_ctrl_t;

endpackage

// ==== logic/phase_sequencer.sv ====
// instruction phase sequencer
`timescale 1ns/1ps

module phase_sequencer (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    active,
    input  sigma_cpu_pkg::instr_t   instr,
    output sigma_cpu_pkg::phase_e   phase,
    output sigma_cpu_pkg::dp_ctrl_t ctrl,
    output logic                    load_effective,
    output logic                    restore_next
);
    import sigma_cpu_pkg::*;

    phase_e phase_next;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            phase <= FETCH;
        end else if (active) begin
            phase <= phase_next;
        end
    end

    always_comb begin
        ctrl           = '0;
        ctrl.sum_op    = PASS_D;
        load_effective = 1'b0;
        restore_next   = 1'b0;
        phase_next     = FETCH;
        case (phase)
            // decoder is transparent here, so the indirect bit is already visible
            FETCH: phase_next = instr.indirect ? PREP1 : PREP2;
            PREP1: phase_next = PREP2;
            PREP2: begin
                ctrl.load_accumulator = 1'b1;
                ctrl.load_operand     = 1'b1;
                load_effective        = 1'b1;
                phase_next            = EXEC1;
            end
            EXEC1: begin
                case (instr.opcode)
                    OP_LI: begin
                        ctrl.write_register = 1'b1;
                        restore_next        = 1'b1;
                        phase_next          = EXEC2;
                    end
                    OP_LB: begin
                        ctrl.load_operand = 1'b1;
                        phase_next        = EXEC2;
                    end
                    OP_STB: begin
                        // operand is zero for STB, so the sum bus carries the accumulator
                        ctrl.sum_op        = ADD;
                        ctrl.store_request = 1'b1;
                        phase_next         = EXEC2;
                    end
                    // target already in the counter from PREP2
                    OP_BAL: ctrl.write_register = 1'b1;
                    default: restore_next = 1'b1;
                endcase
            end
            EXEC2: begin
                case (instr.opcode)
                    OP_LI: ctrl.test_accumulator = 1'b1;
                    OP_LB: begin
                        ctrl.write_register = 1'b1;
                        restore_next        = 1'b1;
                        phase_next          = EXEC3;
                    end
                    OP_STB: begin
                        restore_next = 1'b1;
                        phase_next   = EXEC3;
                    end
                    default: phase_next = FETCH;
                endcase
            end
            EXEC3: ctrl.test_accumulator = (instr.opcode == OP_LB);
            default: phase_next = FETCH;
        endcase
    end

endmodule

// ==== logic/instruction_decoder.sv ====
// instruction register and field decode
`timescale 1ns/1ps
`include "sigma_cpu_consts.svh"

module instruction_decoder (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      active,
    input  sigma_cpu_pkg::phase_e     phase,
    input  logic [`CPU_WORD_BITS-1:0] fetch_word,
    output sigma_cpu_pkg::instr_t     instr
);
    import sigma_cpu_pkg::*;

    localparam int W   = `CPU_WORD_BITS;
    localparam int IMM = `CPU_IMM_BITS;

    logic [W-1:0] ir;
    logic [W-1:0] word;
    logic [6:0]   op;
    logic         is_imm;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ir <= '0;
        end else if (active && phase == FETCH) begin
            ir <= fetch_word;
        end
    end

    always_comb begin
        // fields come straight from memory during FETCH
        word            = (phase == FETCH) ? fetch_word : ir;
        op              = word[30:24];
        // immediate class has opcode bits 3 to 5 clear
        is_imm          = (word[28:26] == 3'b000);
        instr.opcode    = opcode_e'(op);
        instr.reg_num   = word[23:20];
        instr.index_num = word[19:17];
        instr.indirect  = word[31] & ~is_imm;
        instr.fam_b     = op[6] & op[5] & op[4];
        instr.fam_h     = op[6] & ~op[5] & op[4];
        instr.fam_w     = (~op[6] & op[5] & op[4]) | (~op[4] & ~op[3] & op[2]) |
                          (op[6] & ~op[4] & op[3]) | (op[5] & ~op[4] & op[3]);
        instr.immediate = is_imm ? {{(W - IMM){word[IMM-1]}}, word[IMM-1:0]} : '0;
    end

endmodule

// ==== logic/address_unit.sv ====
// program counter and effective address
`timescale 1ns/1ps
`include "sigma_cpu_consts.svh"

module address_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      active,
    input  sigma_cpu_pkg::phase_e     phase,
    input  sigma_cpu_pkg::instr_t     instr,
    input  logic [`CPU_WORD_BITS-1:0] index_value,
    input  logic [`CPU_WORD_BITS-1:0] indirect_word,
    input  logic                      load_effective,
    input  logic                      restore_next,
    output logic [1:0]                byte_select,
    output logic [`CPU_ADDR_BITS-1:0] return_address,
    output logic [`CPU_ADDR_BITS-1:0] memory_address
);
    import sigma_cpu_pkg::*;

    localparam int AW = `CPU_ADDR_BITS;
    localparam int PW = AW + 2;

    // byte-resolution counter
    logic [PW-1:0] pc;
    logic [AW-1:0] operand;
    logic [PW-1:0] index_offset;
    logic [PW-1:0] effective;

    // index scaled to bytes by address family
    always_comb begin
        if (instr.fam_b) begin
            index_offset = index_value[PW-1:0];
        end else if (instr.fam_h) begin
            index_offset = {index_value[PW-2:0], 1'b0};
        end else if (instr.fam_w) begin
            index_offset = {index_value[PW-3:0], 2'b00};
        end else begin
            index_offset = '0;
        end
        effective = {operand, 2'b00} + index_offset;
    end

    assign memory_address = (phase == PREP1) ? operand : pc[PW-1:2];
    assign byte_select    = pc[1:0];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc             <= {`CPU_RESET_WORD, 2'b00};
            operand        <= '0;
            return_address <= '0;
        end else if (active) begin
            if (phase == FETCH || phase == PREP1) begin
                // address field of the instruction, then of the indirect word
                operand <= indirect_word[AW-1:0];
            end
            if (phase == FETCH) begin
                pc <= pc + PW'(4);
            end else if (load_effective) begin
                return_address <= pc[PW-1:2];
                pc             <= effective;
            end else if (restore_next) begin
                pc <= {return_address, 2'b00};
            end
        end
    end

endmodule

// ==== logic/register_file.sv ====
// private register file
`timescale 1ns/1ps
`include "sigma_cpu_consts.svh"

module register_file (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      active,
    input  logic [3:0]                reg_num,
    input  logic [2:0]                index_num,
    input  logic                      write_register,
    input  logic [`CPU_WORD_BITS-1:0] write_data,
    input  logic [`CPU_ADDR_BITS-1:0] memory_address,
    input  logic [`CPU_WORD_BITS-1:0] memory_data_in,
    output logic [`CPU_WORD_BITS-1:0] reg_data,
    output logic [`CPU_WORD_BITS-1:0] index_value,
    output logic [`CPU_WORD_BITS-1:0] fetch_word
);
    localparam int RB = $clog2(`CPU_PRIVATE_REGS);

    logic [`CPU_WORD_BITS-1:0] regs [`CPU_PRIVATE_REGS];
    logic                      private_hit;

    // low word addresses read the registers instead of memory
    assign private_hit = (memory_address < `CPU_ADDR_BITS'(`CPU_PRIVATE_REGS));
    assign fetch_word  = private_hit ? regs[memory_address[RB-1:0]] : memory_data_in;
    assign reg_data    = regs[reg_num];
    // index register 0 means no index
    assign index_value = (index_num == 3'd0) ? '0 : regs[{1'b0, index_num}];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `CPU_PRIVATE_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (active && write_register) begin
            regs[reg_num] <= write_data;
        end
    end

endmodule

// ==== logic/datapath.sv ====
// accumulator, operand and sum bus
`timescale 1ns/1ps
`include "sigma_cpu_consts.svh"

module datapath (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      active,
    input  sigma_cpu_pkg::dp_ctrl_t   ctrl,
    input  sigma_cpu_pkg::instr_t     instr,
    input  logic [`CPU_WORD_BITS-1:0] reg_data,
    input  logic [`CPU_WORD_BITS-1:0] fetch_word,
    input  logic [`CPU_ADDR_BITS-1:0] return_address,
    input  logic [1:0]                byte_select,
    output logic [`CPU_WORD_BITS-1:0] write_data,
    output logic [1:4]                cc
);
    import sigma_cpu_pkg::*;

    localparam int W = `CPU_WORD_BITS;

    logic [W-1:0] accumulator;
    logic [W-1:0] operand;
    logic [W-1:0] operand_in;
    logic [W-1:0] d_bus;
    logic [W-1:0] sum_bus;
    logic [7:0]   mem_byte;

    always_comb begin
        // lane 0 sits in the top byte
        mem_byte   = fetch_word[(W - 8) - 8 * byte_select +: 8];
        operand_in = (instr.opcode == OP_LB) ? {{(W - 8){1'b0}}, mem_byte} : instr.immediate;
        // BAL links the next instruction address
        d_bus      = (instr.opcode == OP_BAL) ?
                     {{(W - `CPU_ADDR_BITS){1'b0}}, return_address} : operand;
        sum_bus    = (ctrl.sum_op == ADD) ? accumulator + d_bus : d_bus;
    end

    assign write_data = sum_bus;

    always_ff @(posedge clock) begin
        if (active) begin
            if (ctrl.load_operand) begin
                operand <= operand_in;
            end
            // accumulator mirrors the named register
            if (ctrl.load_accumulator) begin
                accumulator <= reg_data;
            end else if (ctrl.write_register) begin
                accumulator <= sum_bus;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cc <= '0;
        end else if (active && ctrl.test_accumulator) begin
            cc <= {2'b00, ~accumulator[W-1] & (accumulator != '0), accumulator[W-1]};
        end
    end

endmodule

// ==== logic/store_unit.sv ====
// byte store lane placement
`timescale 1ns/1ps
`include "sigma_cpu_consts.svh"

module store_unit (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       active,
    input  logic                       store_request,
    input  logic [1:0]                 byte_select,
    input  logic [7:0]                 store_byte,
    output logic [`CPU_WORD_BITS-1:0]  memory_data_out,
    output logic [`CPU_BYTE_LANES-1:0] wr_enables
);
    localparam int W     = `CPU_WORD_BITS;
    localparam int LANES = `CPU_BYTE_LANES;

    logic [LANES-1:0] lane_onehot;
    logic [W-1:0]     lane_data;
    logic [LANES-1:0] lane_q;
    logic [W-1:0]     data_q;

    // enable bit 3 and the top byte are lane 0
    assign lane_onehot = {1'b1, {(LANES - 1){1'b0}}} >> byte_select;
    assign lane_data   = {store_byte, {(W - 8){1'b0}}} >> {byte_select, 3'b000};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lane_q <= '0;
            data_q <= '0;
        end else if (active) begin
            lane_q <= store_request ? lane_onehot : '0;
            data_q <= store_request ? lane_data : '0;
        end
    end

    // pending write waits out a stall
    assign wr_enables      = active ? lane_q : '0;
    assign memory_data_out = active ? data_q : '0;

endmodule

// ==== logic/sigma_cpu.sv ====
// sigma cpu core
`timescale 1ns/1ps
`include "sigma_cpu_consts.svh"

module sigma_cpu (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       active,
    input  logic [`CPU_WORD_BITS-1:0]  memory_data_in,
    output logic [`CPU_ADDR_BITS-1:0]  memory_address,
    output logic [`CPU_WORD_BITS-1:0]  memory_data_out,
    output logic [`CPU_BYTE_LANES-1:0] wr_enables,
    output logic [1:4]                 cc
);
    import sigma_cpu_pkg::*;

    phase_e                    phase;
    instr_t                    instr;
    dp_ctrl_t                  ctrl;
    logic                      load_effective;
    logic                      restore_next;
    logic [1:0]                byte_select;
    logic [`CPU_ADDR_BITS-1:0] return_address;
    logic [`CPU_WORD_BITS-1:0] reg_data;
    logic [`CPU_WORD_BITS-1:0] index_value;
    logic [`CPU_WORD_BITS-1:0] fetch_word;
    logic [`CPU_WORD_BITS-1:0] write_data;

    phase_sequencer i_sequencer (
        .clock, .reset, .active, .instr, .phase, .ctrl, .load_effective, .restore_next
    );

    instruction_decoder i_decoder (
        .clock, .reset, .active, .phase, .fetch_word, .instr
    );

    // fetch_word carries the indirect word while in PREP1
    address_unit i_address (
        .clock, .reset, .active, .phase, .instr, .index_value,
        .indirect_word(fetch_word), .load_effective, .restore_next,
        .byte_select, .return_address, .memory_address
    );

    register_file i_registers (
        .clock, .reset, .active,
        .reg_num(instr.reg_num), .index_num(instr.index_num),
        .write_register(ctrl.write_register), .write_data,
        .memory_address, .memory_data_in, .reg_data, .index_value, .fetch_word
    );

    datapath i_datapath (
        .clock, .reset, .active, .ctrl, .instr, .reg_data, .fetch_word,
        .return_address, .byte_select, .write_data, .cc
    );

    // STB sends the low byte of the sum bus
    store_unit i_store (
        .clock, .reset, .active, .store_request(ctrl.store_request), .byte_select,
        .store_byte(write_data[7:0]), .memory_data_out, .wr_enables
    );

endmodule

// ==== dv/sigma_cpu_asserts.sv ====
// sigma cpu assertions
`timescale 1ns/1ps
`include "sigma_cpu_consts.svh"

module sigma_cpu_asserts (
    input logic                       clock,
    input logic                       reset,
    input logic                       active,
    input logic [`CPU_ADDR_BITS-1:0]  memory_address,
    input logic [`CPU_WORD_BITS-1:0]  memory_data_in,
    input logic [`CPU_WORD_BITS-1:0]  memory_data_out,
    input logic [`CPU_BYTE_LANES-1:0] wr_enables,
    input logic [1:4]                 cc,
    input sigma_cpu_pkg::phase_e      phase,
    input sigma_cpu_pkg::instr_t      instr
);
    import sigma_cpu_pkg::*;

    int         fail_count = 0;
    logic [1:4] li_cc;
    logic       li_test;
    logic       bal_self_fetch;

    // byte mask of the enabled lanes, enable bit 3 is the top byte
    function automatic logic [31:0] lane_mask(input logic [3:0] we);
        logic [31:0] mask;
        for (int i = 0; i < 4; i++) begin
            mask[8 * i +: 8] = {8{we[i]}};
        end
        return mask;
    endfunction

    // condition code expected from the sign of the loaded immediate
    assign li_cc   = ($signed(instr.immediate) > 0) ? 4'b0010 :
                     ($signed(instr.immediate) < 0) ? 4'b0001 : 4'b0000;
    assign li_test = active && phase == EXEC2 && instr.opcode == OP_LI;

    // a fetch of a branch whose target is its own word
    assign bal_self_fetch = active && phase == FETCH && instr.opcode == OP_BAL &&
                            instr.index_num == 3'd0 && !memory_data_in[31] &&
                            memory_data_in[`CPU_ADDR_BITS-1:0] == memory_address;

    a_we_onehot: assert property (@(posedge clock) $onehot0(wr_enables))
        else begin
            fail_count++;
            $error("write enables have more than one lane set");
        end

    a_we_idle: assert property (@(posedge clock) (reset || !active) |-> wr_enables == '0)
        else begin
            fail_count++;
            $error("write enables set during reset or stall");
        end

    a_data_lane: assert property (@(posedge clock)
        (memory_data_out & ~lane_mask(wr_enables)) == '0)
        else begin
            fail_count++;
            $error("store data outside the enabled lane");
        end

    a_cc_exclusive: assert property (@(posedge clock) !(cc[3] && cc[4]))
        else begin
            fail_count++;
            $error("condition code positive and negative together");
        end

    a_li_cc: assert property (@(posedge clock) disable iff (reset)
        li_test |=> cc == $past(li_cc))
        else begin
            fail_count++;
            $error("condition code wrong after load immediate");
        end

    // fetch, prep2 and exec1 bring the counter back to the loop word
    a_bal_loop: assert property (@(posedge clock) disable iff (reset)
        $past(bal_self_fetch, 3) && $past(active, 2) && $past(active) && active
            |-> memory_address == $past(memory_address, 3))
        else begin
            fail_count++;
            $error("branch loop did not return to its own address");
        end

endmodule

// ==== dv/sigma_cpu_tb.sv ====
// sigma cpu testbench
`timescale 1ns/1ps
`include "sigma_cpu_consts.svh"

module sigma_cpu_tb;
    import sigma_cpu_pkg::*;

    localparam int MEM_WORDS   = 1 << `CPU_ADDR_BITS;
    localparam int LIMIT       = 400;
    localparam int LOOP_WORD   = 'h2F;
    localparam int LOOP_PASSES = 3;

    logic                       clock;
    logic                       reset;
    logic                       active;
    logic [`CPU_WORD_BITS-1:0]  memory_data_in;
    logic [`CPU_ADDR_BITS-1:0]  memory_address;
    logic [`CPU_WORD_BITS-1:0]  memory_data_out;
    logic [`CPU_BYTE_LANES-1:0] wr_enables;
    logic [1:4]                 cc;

    logic [31:0] mem [MEM_WORDS];
    int          seed = 32'h21d51544;
    int          cycles = 0;
    int          mismatches = 0;
    int          loop_fetches = 0;
    int          errors;
    logic [31:0] ones = 32'hFFFF_FFFF;
    logic        stall_enable = 1'b1;

    sigma_cpu i_dut (
        .clock, .reset, .active, .memory_data_in, .memory_address,
        .memory_data_out, .wr_enables, .cc
    );

    bind sigma_cpu sigma_cpu_asserts i_asserts (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // combinational read, byte-enabled write
    assign memory_data_in = mem[memory_address];

    always @(posedge clock) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_enables[i]) begin
                mem[memory_address][8 * i +: 8] <= memory_data_out[8 * i +: 8];
            end
        end
    end

    // random stalls, low about one cycle in four
    // stalls stop once the loop is reached, so later passes run unbroken
    always @(posedge clock) begin
        active <= !stall_enable || (($random(seed) & 3) != 0);
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: program did not reach its loop within %0d cycles", LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] imm_instr(input opcode_e op, input logic [3:0] r,
                                              input logic [19:0] imm);
        return {1'b0, op, r, imm};
    endfunction

    function automatic logic [31:0] mem_instr(input logic ind, input opcode_e op,
                                              input logic [3:0] r, input logic [2:0] x,
                                              input logic [16:0] addr);
        return {ind, op, r, x, addr};
    endfunction

    function automatic logic [31:0] sign_extend(input logic [19:0] v);
        return {{12{v[19]}}, v};
    endfunction

    // lane 0 is the most significant byte
    function automatic logic [7:0] byte_of(input logic [31:0] w, input int lane);
        return w[31 - 8 * lane -: 8];
    endfunction

    function automatic logic [31:0] put_byte(input logic [31:0] w, input int lane,
                                             input logic [7:0] b);
        logic [31:0] r;
        r = w;
        r[31 - 8 * lane -: 8] = b;
        return r;
    endfunction

    task automatic check_word(input string name, input int addr, input logic [31:0] exp);
        if (mem[addr] !== exp) begin
            $display("mismatch %s: expected %08h actual %08h", name, exp, mem[addr]);
            mismatches++;
        end
    endtask

    task automatic load_program;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = {a[15:0], ~a[15:0]} ^ {31'd0, a[16]};
        end
        mem['h25] = imm_instr(OP_LI, 4'd1, 20'hFFFA5);
        mem['h26] = imm_instr(OP_LI, 4'd2, 20'd6);
        mem['h27] = mem_instr(1'b0, OP_STB, 4'd1, 3'd2, 17'h200);
        mem['h28] = imm_instr(OP_LI, 4'd3, 20'd0);
        mem['h29] = imm_instr(OP_LI, 4'd4, 20'd9);
        mem['h2A] = mem_instr(1'b0, OP_LB, 4'd5, 3'd4, 17'h100);
        mem['h2B] = mem_instr(1'b0, OP_STB, 4'd5, 3'd0, 17'h202);
        mem['h2C] = mem_instr(1'b1, OP_LB, 4'd6, 3'd0, 17'h110);
        mem['h2D] = imm_instr(OP_LI, 4'd7, 20'd3);
        mem['h2E] = mem_instr(1'b0, OP_STB, 4'd6, 3'd7, 17'h200);
        mem['h2F] = mem_instr(1'b0, OP_BAL, 4'd15, 3'd0, 17'(LOOP_WORD));
        // data words and the all-ones result area
        mem['h102] = 32'h11C3_5577;
        mem['h110] = 32'h0000_0120;
        mem['h120] = 32'h9ABC_DEF0;
        for (int a = 'h200; a <= 'h204; a++) begin
            mem[a] = ones;
        end
    endtask

    initial begin
        reset  = 1'b1;
        active = 1'b1;
        load_program();
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        // the loop word is fetched again on every pass
        while (loop_fetches < LOOP_PASSES) begin
            @(posedge clock);
            if (active && i_dut.phase == FETCH && memory_address == LOOP_WORD) begin
                loop_fetches++;
                stall_enable <= 1'b0;
            end
        end
        repeat (4) @(posedge clock);

        // byte 0x806 is word 0x201 lane 2
        check_word("negative li store", 'h201,
                   put_byte(ones, 2, byte_of(sign_extend(20'hFFFA5), 3)));
        // byte 0x409 is word 0x102 lane 1
        check_word("indexed lb store", 'h202, put_byte(ones, 0, byte_of(32'h11C3_5577, 1)));
        // pointer at 0x110 leads to word 0x120, byte 0x803 is word 0x200 lane 3
        check_word("indirect lb store", 'h200, put_byte(ones, 3, byte_of(32'h9ABC_DEF0, 0)));
        check_word("untouched word 0x203", 'h203, ones);
        check_word("untouched word 0x204", 'h204, ones);

        errors = mismatches + i_dut.i_asserts.fail_count;
        $display("errors: %0d mismatches, %0d assertion failures",
                 mismatches, i_dut.i_asserts.fail_count);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== sigma_cpu.f ====
+incdir+logic
logic/sigma_cpu_pkg.sv
logic/phase_sequencer.sv
logic/instruction_decoder.sv
logic/address_unit.sv
logic/register_file.sv
logic/datapath.sv
logic/store_unit.sv
logic/sigma_cpu.sv
dv/sigma_cpu_asserts.sv
dv/sigma_cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sigma_cpu_tb
FILELIST  ?= sigma_cpu.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
RUNFLAGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := logic/sigma_cpu_consts.svh
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG); grep -q '^SIMULATION PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
